/* verilog/f2_pkg.sv */
`default_nettype none

package f2_pkg;

    ////////////////////////////////////////
    // Widths

    typedef logic [23:0] cpu_addr_t;
    typedef logic [15:0] cpu_word_t;
    typedef logic [26:0] sdr_addr_t;
    typedef logic [31:0] ssp_t;
    typedef logic [2:0]  ipl_t;

    // Current 68000 bus cycle, word_addr is a byte address with bit 0 clear
    typedef struct packed {
        cpu_addr_t   word_addr;
        logic [1:0]  ds_n;
        logic        rw;
        logic [2:0]  fc;
        cpu_word_t   dout;
    } cpu_bus_t;

    // SDRAM port, req toggles once per access
    typedef struct packed {
        sdr_addr_t   addr;
        cpu_word_t   data;
        logic [1:0]  be;
        logic        rw;
        logic        req;
    } sdr_req_t;

    typedef enum logic [3:0] {
        IDLE,
        START_SAVE,
        WAIT_SAVE,
        SAVE_SETTLE,
        SAVE_ACTIVE,
        RESTORE_SETTLE,
        RESTORE_ACTIVE,
        HOLD_RESET,
        WAIT_RESTART
    } ss_state_t;

    ////////////////////////////////////////
    // Address map

    localparam cpu_addr_t ROM_LIMIT       = 24'h07ffff;
    localparam cpu_addr_t WORK_RAM_BASE   = 24'h100000;
    localparam cpu_addr_t SS_HANDLER_BASE = 24'hff0000;
    localparam cpu_addr_t AUTOVEC7_ADDR   = 24'h00007c;

    localparam sdr_addr_t CPU_ROM_SDR_BASE  = 27'h0000000;
    localparam sdr_addr_t WORK_RAM_SDR_BASE = 27'h0100000;

    // Save handler code, word 4 is the restart entry
    localparam cpu_word_t SAVE_HANDLER [13] = '{
        16'h48e7, 16'hfffe, 16'h4e6e, 16'h2f0e,
        16'h4df9, 16'h00ff, 16'h0000, 16'h2c8f,
        16'h2c5f, 16'h4e66, 16'h4cdf, 16'h7fff,
        16'h4e73
    };

    localparam ssp_t RESTART_PC = 32'h00ff0008;

    localparam ipl_t IPL_VBL  = 3'd5;
    localparam ipl_t IPL_DMA  = 3'd6;
    localparam ipl_t IPL_SAVE = 3'd7;

endpackage

`default_nettype wire

/* verilog/irq_controller.sv */
`timescale 1ns/1ps
`default_nettype none

module irq_controller (
    input  logic             clk,
    input  logic             reset,
    input  f2_pkg::cpu_bus_t cpu,
    input  logic             vblank_n,
    input  logic             dma_n,
    input  logic             ss_do_save,
    output f2_pkg::ipl_t     ipl_n
);

    logic vbl_prev;
    logic dma_prev;
    logic save_prev;

    logic vbl_req;
    logic dma_req;
    logic save_req;

    logic         iack;
    f2_pkg::ipl_t ack_level;
    f2_pkg::ipl_t level;

    // Interrupt acknowledge, level on A3..A1
    assign iack      = (cpu.fc == 3'b111) && !cpu.ds_n[0];
    assign ack_level = cpu.word_addr[3:1];

    always_ff @(posedge clk) begin
        vbl_prev  <= vblank_n;
        dma_prev  <= dma_n;
        save_prev <= ss_do_save;

        if (reset) begin
            vbl_req  <= 1'b0;
            dma_req  <= 1'b0;
            save_req <= 1'b0;
        end else begin
            if (vbl_prev && !vblank_n) begin
                vbl_req <= 1'b1;
            end
            if (!dma_prev && dma_n) begin
                dma_req <= 1'b1;
            end
            if (!save_prev && ss_do_save) begin
                save_req <= 1'b1;
            end

            // Clear wins over a new edge in the same cycle
            if (iack && ack_level == f2_pkg::IPL_VBL) begin
                vbl_req <= 1'b0;
            end
            if (iack && ack_level == f2_pkg::IPL_DMA) begin
                dma_req <= 1'b0;
            end
            if (iack && ack_level == f2_pkg::IPL_SAVE) begin
                save_req <= 1'b0;
            end
        end
    end

    assign level = save_req ? f2_pkg::IPL_SAVE :
                   dma_req  ? f2_pkg::IPL_DMA :
                   vbl_req  ? f2_pkg::IPL_VBL :
                   3'd0;

    assign ipl_n = ~level;

endmodule

`default_nettype wire

/* verilog/ss_sequencer.sv */
`timescale 1ns/1ps
`default_nettype none

module ss_sequencer #(
    parameter int SETTLE_CYCLES = 64,
    parameter int HOLD_CYCLES   = 1000
) (
    input  logic              clk,
    input  logic              reset,
    input  logic              ss_do_save,
    input  logic              ss_do_restore,
    input  logic              ssp_hi_wr,
    input  logic              ssp_lo_wr,
    input  f2_pkg::cpu_word_t cpu_dout,
    input  logic              ss_busy,
    input  f2_pkg::ssp_t      restore_ssp,
    output logic              ss_write,
    output logic              ss_read,
    output logic              cpu_pause,
    output logic              ss_reset,
    output logic              restart,
    output f2_pkg::ssp_t      saved_ssp,
    output f2_pkg::ssp_t      restore_vec,
    output f2_pkg::ss_state_t state
);

    localparam int CNT_MAX = (SETTLE_CYCLES > HOLD_CYCLES) ? SETTLE_CYCLES : HOLD_CYCLES;
    localparam int CNT_W   = $clog2(CNT_MAX + 1);

    logic [CNT_W-1:0] count;
    logic             save_prev;
    logic             restore_prev;

    logic hi_capture;
    logic lo_capture;
    logic restore_done;

    assign hi_capture   = (state == f2_pkg::START_SAVE) && ssp_hi_wr;
    assign lo_capture   = (state == f2_pkg::WAIT_SAVE) && ssp_lo_wr;
    assign restore_done = (state == f2_pkg::RESTORE_ACTIVE) && !ss_busy && !ss_read;

    ////////////////////////////////////////
    // FSM

    always_ff @(posedge clk) begin
        if (reset) begin
            state        <= f2_pkg::IDLE;
            ss_write     <= 1'b0;
            ss_read      <= 1'b0;
            count        <= '0;
            save_prev    <= 1'b0;
            restore_prev <= 1'b0;
        end else begin
            save_prev    <= ss_do_save;
            restore_prev <= ss_do_restore;
            count        <= count + 1'b1;

            case (state)
                f2_pkg::IDLE: begin
                    // Restore has priority
                    if (ss_do_restore && !restore_prev) begin
                        state <= f2_pkg::RESTORE_SETTLE;
                        count <= '0;
                    end else if (ss_do_save && !save_prev) begin
                        state <= f2_pkg::START_SAVE;
                    end
                end

                f2_pkg::START_SAVE: begin
                    if (hi_capture) begin
                        state <= f2_pkg::WAIT_SAVE;
                    end
                end

                f2_pkg::WAIT_SAVE: begin
                    if (lo_capture) begin
                        state <= f2_pkg::SAVE_SETTLE;
                        count <= '0;
                    end
                end

                f2_pkg::SAVE_SETTLE: begin
                    if (count == CNT_W'(SETTLE_CYCLES)) begin
                        ss_write <= 1'b1;
                        state    <= f2_pkg::SAVE_ACTIVE;
                    end
                end

                f2_pkg::SAVE_ACTIVE: begin
                    if (ss_busy && ss_write) begin
                        ss_write <= 1'b0;
                    end else if (!ss_busy && !ss_write) begin
                        state <= f2_pkg::IDLE;
                    end
                end

                f2_pkg::RESTORE_SETTLE: begin
                    if (count == CNT_W'(SETTLE_CYCLES)) begin
                        ss_read <= 1'b1;
                        state   <= f2_pkg::RESTORE_ACTIVE;
                    end
                end

                f2_pkg::RESTORE_ACTIVE: begin
                    if (ss_busy && ss_read) begin
                        ss_read <= 1'b0;
                    end else if (restore_done) begin
                        state <= f2_pkg::HOLD_RESET;
                        count <= '0;
                    end
                end

                f2_pkg::HOLD_RESET: begin
                    if (count == CNT_W'(HOLD_CYCLES)) begin
                        state <= f2_pkg::WAIT_RESTART;
                    end
                end

                f2_pkg::WAIT_RESTART: begin
                    // Handler stores SP again, low half ends the restart
                    if (ssp_lo_wr) begin
                        state <= f2_pkg::IDLE;
                    end
                end

                default: begin
                    state <= f2_pkg::IDLE;
                end
            endcase
        end
    end

    ////////////////////////////////////////
    // Stack pointer capture

    always_ff @(posedge clk) begin
        if (hi_capture) begin
            saved_ssp[31:16] <= cpu_dout;
        end
        if (lo_capture) begin
            saved_ssp[15:0] <= cpu_dout;
        end
        if (restore_done) begin
            restore_vec <= restore_ssp;
        end
    end

    assign cpu_pause = (state == f2_pkg::SAVE_SETTLE) ||
                       (state == f2_pkg::SAVE_ACTIVE) ||
                       (state == f2_pkg::RESTORE_ACTIVE);

    assign ss_reset = (state == f2_pkg::RESTORE_SETTLE) || (state == f2_pkg::HOLD_RESET);

    assign restart = (state == f2_pkg::WAIT_RESTART);

endmodule

`default_nettype wire

/* verilog/cpu_bus_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module cpu_bus_decode (
    input  f2_pkg::cpu_bus_t  cpu,
    input  logic              restart,
    input  f2_pkg::ssp_t      restore_vec,
    input  f2_pkg::cpu_word_t sdr_q,
    output logic              rom_sel,
    output logic              work_sel,
    output logic              ssp_hi_wr,
    output logic              ssp_lo_wr,
    output f2_pkg::cpu_word_t cpu_din
);

    f2_pkg::cpu_addr_t addr;

    logic       restart_sel;
    logic       autovec_sel;
    logic       handler_sel;
    logic       wr_word;
    logic [3:0] handler_idx;

    assign addr        = cpu.word_addr;
    assign handler_idx = addr[4:1];

    // Reset vectors are replaced while the CPU restarts
    assign restart_sel = restart && (addr[23:3] == '0);
    assign autovec_sel = (addr[23:2] == f2_pkg::AUTOVEC7_ADDR[23:2]);
    assign handler_sel = (addr[23:5] == f2_pkg::SS_HANDLER_BASE[23:5]);

    assign rom_sel  = (addr <= f2_pkg::ROM_LIMIT) && !restart_sel && !autovec_sel;
    assign work_sel = (addr[23:16] == f2_pkg::WORK_RAM_BASE[23:16]);

    // Stack pointer halves written by the handler
    assign wr_word   = !cpu.rw && (cpu.ds_n == 2'b00);
    assign ssp_hi_wr = handler_sel && wr_word && (handler_idx == 4'd0);
    assign ssp_lo_wr = handler_sel && wr_word && (handler_idx == 4'd1);

    ////////////////////////////////////////
    // Read data

    always_comb begin
        cpu_din = '0;
        if (restart_sel) begin
            case (addr[2:1])
                2'd0: cpu_din = restore_vec[31:16];
                2'd1: cpu_din = restore_vec[15:0];
                2'd2: cpu_din = f2_pkg::RESTART_PC[31:16];
                default: cpu_din = f2_pkg::RESTART_PC[15:0];
            endcase
        end else if (autovec_sel) begin
            // Level 7 autovector points at the handler
            cpu_din = addr[1] ? 16'h0000 : 16'h00ff;
        end else if (rom_sel || work_sel) begin
            cpu_din = sdr_q;
        end else if (handler_sel && handler_idx < 4'($size(f2_pkg::SAVE_HANDLER))) begin
            cpu_din = f2_pkg::SAVE_HANDLER[handler_idx];
        end
    end

endmodule

`default_nettype wire

/* verilog/sdr_cpu_bridge.sv */
`timescale 1ns/1ps
`default_nettype none

module sdr_cpu_bridge (
    input  logic             clk,
    input  logic             reset,
    input  f2_pkg::cpu_bus_t cpu,
    input  logic             rom_sel,
    input  logic             work_sel,
    input  logic             sdr_ack,
    output f2_pkg::sdr_req_t sdr,
    output logic             dtack_n
);

    f2_pkg::sdr_addr_t addr_q;
    f2_pkg::cpu_word_t data_q;
    logic [1:0]        be_q;
    logic              rw_q;
    logic              req_q;

    logic strobes_idle_q;
    logic cycle_active;
    logic sdr_sel;
    logic start;
    logic pending;

    assign cycle_active = !(&cpu.ds_n);
    assign sdr_sel      = rom_sel || work_sel;

    // One request on the first strobe cycle only
    assign start   = sdr_sel && cycle_active && strobes_idle_q;
    assign pending = (req_q != sdr_ack);

    always_ff @(posedge clk) begin
        if (reset) begin
            strobes_idle_q <= 1'b1;
            req_q          <= 1'b0;
        end else begin
            strobes_idle_q <= !cycle_active;
            if (start) begin
                req_q <= ~req_q;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            if (rom_sel) begin
                addr_q <= f2_pkg::CPU_ROM_SDR_BASE + {3'b0, cpu.word_addr};
            end else begin
                addr_q <= f2_pkg::WORK_RAM_SDR_BASE + {11'b0, cpu.word_addr[15:0]};
            end
            data_q <= cpu.dout;
            be_q   <= ~cpu.ds_n;
            rw_q   <= cpu.rw;
        end
    end

    assign sdr = '{addr: addr_q, data: data_q, be: be_q, rw: rw_q, req: req_q};

    // SDRAM regions wait for the ack, everything else answers at once
    assign dtack_n = !cycle_active || (sdr_sel && (start || pending));

endmodule

`default_nettype wire

/* verilog/f2_cpu_support.sv */
`timescale 1ns/1ps
`default_nettype none

module f2_cpu_support #(
    parameter int SETTLE_CYCLES = 64,
    parameter int HOLD_CYCLES   = 1000
) (
    input  logic              clk,
    input  logic              reset,

    // CPU
    input  f2_pkg::cpu_bus_t  cpu,
    output f2_pkg::cpu_word_t cpu_din,
    output logic              dtack_n,
    output f2_pkg::ipl_t      ipl_n,
    output logic              cpu_reset,
    output logic              cpu_pause,

    // SDRAM
    output f2_pkg::sdr_req_t  sdr,
    input  logic              sdr_ack,
    input  f2_pkg::cpu_word_t sdr_q,

    // State storage engine
    output logic              ss_write,
    output logic              ss_read,
    input  logic              ss_busy,
    input  f2_pkg::ssp_t      restore_ssp,

    input  logic              vblank_n,
    input  logic              dma_n,
    input  logic              ss_do_save,
    input  logic              ss_do_restore,
    output f2_pkg::ssp_t      saved_ssp,
    output f2_pkg::ss_state_t ss_state
);

    logic         rom_sel;
    logic         work_sel;
    logic         ssp_hi_wr;
    logic         ssp_lo_wr;
    logic         restart;
    logic         ss_reset;
    f2_pkg::ssp_t restore_vec;

    irq_controller u_irq (
        .clk        (clk),
        .reset      (reset),
        .cpu        (cpu),
        .vblank_n   (vblank_n),
        .dma_n      (dma_n),
        .ss_do_save (ss_do_save),
        .ipl_n      (ipl_n)
    );

    cpu_bus_decode u_decode (
        .cpu         (cpu),
        .restart     (restart),
        .restore_vec (restore_vec),
        .sdr_q       (sdr_q),
        .rom_sel     (rom_sel),
        .work_sel    (work_sel),
        .ssp_hi_wr   (ssp_hi_wr),
        .ssp_lo_wr   (ssp_lo_wr),
        .cpu_din     (cpu_din)
    );

    sdr_cpu_bridge u_bridge (
        .clk      (clk),
        .reset    (reset),
        .cpu      (cpu),
        .rom_sel  (rom_sel),
        .work_sel (work_sel),
        .sdr_ack  (sdr_ack),
        .sdr      (sdr),
        .dtack_n  (dtack_n)
    );

    ss_sequencer #(
        .SETTLE_CYCLES (SETTLE_CYCLES),
        .HOLD_CYCLES   (HOLD_CYCLES)
    ) u_seq (
        .clk           (clk),
        .reset         (reset),
        .ss_do_save    (ss_do_save),
        .ss_do_restore (ss_do_restore),
        .ssp_hi_wr     (ssp_hi_wr),
        .ssp_lo_wr     (ssp_lo_wr),
        .cpu_dout      (cpu.dout),
        .ss_busy       (ss_busy),
        .restore_ssp   (restore_ssp),
        .ss_write      (ss_write),
        .ss_read       (ss_read),
        .cpu_pause     (cpu_pause),
        .ss_reset      (ss_reset),
        .restart       (restart),
        .saved_ssp     (saved_ssp),
        .restore_vec   (restore_vec),
        .state         (ss_state)
    );

    // Restore holds the CPU in reset
    assign cpu_reset = reset || ss_reset;

endmodule

`default_nettype wire

/* tb/tb_f2_cpu_support.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_f2_cpu_support;

    localparam int SETTLE_CYCLES      = 8;
    localparam int HOLD_CYCLES        = 20;
    localparam int ENGINE_BUSY_CYCLES = 4;
    // Whole run takes well under a thousand cycles
    localparam int CYCLE_LIMIT        = 20000;

    localparam logic [2:0]   FC_DATA    = 3'b101;
    localparam logic [2:0]   FC_PROG    = 3'b110;
    localparam logic [2:0]   FC_IACK    = 3'b111;
    localparam f2_pkg::ssp_t RESTORE_SP = 32'h0010_fff0;

    logic              clk;
    logic              reset;
    f2_pkg::cpu_bus_t  cpu;
    f2_pkg::cpu_word_t cpu_din;
    logic              dtack_n;
    f2_pkg::ipl_t      ipl_n;
    logic              cpu_reset;
    logic              cpu_pause;
    f2_pkg::sdr_req_t  sdr;
    logic              sdr_ack;
    f2_pkg::cpu_word_t sdr_q;
    logic              ss_write;
    logic              ss_read;
    logic              ss_busy;
    f2_pkg::ssp_t      restore_ssp;
    logic              vblank_n;
    logic              dma_n;
    logic              ss_do_save;
    logic              ss_do_restore;
    f2_pkg::ssp_t      saved_ssp;
    f2_pkg::ss_state_t ss_state;

    int   seed = 32'h685a_c3e0;
    int   cycle_count = 0;
    int   toggle_count = 0;
    logic req_prev = 1'b0;
    int   dtack_wait;
    logic req_matched;
    int   write_count = 0;
    int   read_count = 0;

    f2_pkg::cpu_word_t sdr_mem [256];
    f2_pkg::sdr_addr_t last_addr;
    f2_pkg::cpu_word_t last_data;
    logic [1:0]        last_be;
    logic              last_rw;

    f2_cpu_support #(
        .SETTLE_CYCLES (SETTLE_CYCLES),
        .HOLD_CYCLES   (HOLD_CYCLES)
    ) uut (
        .clk           (clk),
        .reset         (reset),
        .cpu           (cpu),
        .cpu_din       (cpu_din),
        .dtack_n       (dtack_n),
        .ipl_n         (ipl_n),
        .cpu_reset     (cpu_reset),
        .cpu_pause     (cpu_pause),
        .sdr           (sdr),
        .sdr_ack       (sdr_ack),
        .sdr_q         (sdr_q),
        .ss_write      (ss_write),
        .ss_read       (ss_read),
        .ss_busy       (ss_busy),
        .restore_ssp   (restore_ssp),
        .vblank_n      (vblank_n),
        .dma_n         (dma_n),
        .ss_do_save    (ss_do_save),
        .ss_do_restore (ss_do_restore),
        .saved_ssp     (saved_ssp),
        .ss_state      (ss_state)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("Timeout: run went past %0d cycles", CYCLE_LIMIT);
            $display("TEST FAILED");
            $fatal(1, "watchdog expired");
        end
    end

    // Count SDRAM request toggles
    always @(negedge clk) begin
        if (sdr.req != req_prev) begin
            toggle_count <= toggle_count + 1;
        end
        req_prev <= sdr.req;
    end

    ////////////////////////////////////////
    // Checks and helpers

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("FAILED %s: expected %h, actual %h", name, expected, actual);
            $display("TEST FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic check_true(input logic cond, input string what);
        assert (cond) else begin
            $display("%s", what);
            $display("TEST FAILED");
            $fatal(1, "check failed");
        end
    endtask

    // SDRAM contents before any write
    function automatic f2_pkg::cpu_word_t fill_word(input logic [7:0] idx);
        return {idx ^ 8'h5a, ~idx};
    endfunction

    function automatic f2_pkg::ipl_t expected_ipl(input f2_pkg::ipl_t level);
        return ~level;
    endfunction

    task automatic wait_state(input f2_pkg::ss_state_t target, input int limit);
        int n;
        n = 0;
        @(negedge clk);
        while (ss_state != target) begin
            n++;
            check_true(n < limit, $sformatf("Sequencer never reached %s", target.name()));
            @(negedge clk);
        end
    endtask

    task automatic wait_dtack();
        dtack_wait = 0;
        @(negedge clk);
        while (dtack_n) begin
            dtack_wait++;
            @(negedge clk);
        end
        req_matched = (sdr.req == sdr_ack);
    endtask

    task automatic bus_read(input f2_pkg::cpu_addr_t addr, input logic [2:0] fc,
                            output f2_pkg::cpu_word_t data);
        @(posedge clk);
        cpu <= '{word_addr: addr, ds_n: 2'b00, rw: 1'b1, fc: fc, dout: 16'h0000};
        wait_dtack();
        data = cpu_din;
        @(posedge clk);
        cpu <= '{word_addr: addr, ds_n: 2'b11, rw: 1'b1, fc: FC_DATA, dout: 16'h0000};
    endtask

    task automatic bus_write(input f2_pkg::cpu_addr_t addr, input logic [1:0] ds_n,
                             input f2_pkg::cpu_word_t data);
        @(posedge clk);
        cpu <= '{word_addr: addr, ds_n: ds_n, rw: 1'b0, fc: FC_DATA, dout: data};
        wait_dtack();
        @(posedge clk);
        cpu <= '{word_addr: addr, ds_n: 2'b11, rw: 1'b1, fc: FC_DATA, dout: 16'h0000};
    endtask

    task automatic acknowledge(input f2_pkg::ipl_t level);
        f2_pkg::cpu_word_t data;
        bus_read({20'hfffff, level, 1'b0}, FC_IACK, data);
        @(negedge clk);
    endtask

    ////////////////////////////////////////
    // SDRAM and storage engine models

    initial begin : sdram_model
        int         wait_cycles;
        int         i;
        logic [7:0] idx;
        sdr_ack = 1'b0;
        sdr_q   = '0;
        for (i = 0; i < 256; i++) begin
            sdr_mem[i] = fill_word(8'(i));
        end
        forever begin
            @(negedge clk);
            if (!reset && sdr.req != sdr_ack) begin
                last_addr   = sdr.addr;
                last_data   = sdr.data;
                last_be     = sdr.be;
                last_rw     = sdr.rw;
                idx         = sdr.addr[8:1];
                wait_cycles = 1 + ($unsigned($random(seed)) % 32'd4);
                repeat (wait_cycles - 1) @(negedge clk);
                @(posedge clk);
                if (last_rw) begin
                    sdr_q <= sdr_mem[idx];
                end else begin
                    if (last_be[1]) sdr_mem[idx][15:8] = last_data[15:8];
                    if (last_be[0]) sdr_mem[idx][7:0] = last_data[7:0];
                end
                sdr_ack <= sdr.req;
            end
        end
    end

    initial begin : storage_engine
        logic is_read;
        ss_busy     = 1'b0;
        restore_ssp = '0;
        forever begin
            @(negedge clk);
            if (ss_write || ss_read) begin
                is_read = ss_read;
                @(posedge clk);
                ss_busy <= 1'b1;
                if (is_read) begin
                    restore_ssp <= RESTORE_SP;
                end
                repeat (ENGINE_BUSY_CYCLES) @(posedge clk);
                ss_busy <= 1'b0;
                if (is_read) read_count++;
                else write_count++;
            end
        end
    end

    ////////////////////////////////////////
    // Directed tests

    task automatic interrupt_priority();
        @(posedge clk);
        vblank_n <= 1'b0;
        @(posedge clk);
        @(negedge clk);
        check_value("irq vblank", 32'(expected_ipl(3'd5)), 32'(ipl_n));
        @(posedge clk);
        dma_n <= 1'b1;
        @(posedge clk);
        @(negedge clk);
        check_value("irq dma priority", 32'(expected_ipl(3'd6)), 32'(ipl_n));
        acknowledge(3'd6);
        check_value("irq ack 6", 32'(expected_ipl(3'd5)), 32'(ipl_n));
        acknowledge(3'd5);
        check_value("irq ack 5", 32'(3'b111), 32'(ipl_n));
        @(posedge clk);
        vblank_n <= 1'b1;
    endtask

    task automatic rom_read();
        f2_pkg::cpu_word_t data;
        f2_pkg::sdr_addr_t expect_addr;
        int                toggles;
        expect_addr = f2_pkg::CPU_ROM_SDR_BASE + 27'h0001234;
        toggles     = toggle_count;
        bus_read(24'h001234, FC_PROG, data);
        check_value("rom address", 32'(expect_addr), 32'(last_addr));
        check_value("rom rw", 32'(1'b1), 32'(last_rw));
        check_value("rom be", 32'(2'b11), 32'(last_be));
        check_true(dtack_wait > 0, "dtack_n went low at once on a ROM read");
        check_true(req_matched, "dtack_n went low before the SDRAM acknowledge");
        check_value("rom data", 32'(fill_word(expect_addr[8:1])), 32'(data));
        check_value("rom toggles", 32'(toggles + 1), 32'(toggle_count));
        // Last word of ROM
        expect_addr = f2_pkg::CPU_ROM_SDR_BASE + 27'h007fffe;
        bus_read(24'h07fffe, FC_PROG, data);
        check_value("rom limit address", 32'(expect_addr), 32'(last_addr));
        check_value("rom limit data", 32'(fill_word(expect_addr[8:1])), 32'(data));
        check_value("rom limit toggles", 32'(toggles + 2), 32'(toggle_count));
    endtask

    task automatic work_ram_byte_write();
        f2_pkg::cpu_word_t data;
        f2_pkg::cpu_word_t pattern;
        f2_pkg::sdr_addr_t expect_addr;
        int                toggles;
        expect_addr = f2_pkg::WORK_RAM_SDR_BASE + 27'h0000456;
        toggles     = toggle_count;
        bus_write(24'h100456, 2'b10, 16'hbeef);
        check_value("wram address", 32'(expect_addr), 32'(last_addr));
        check_value("wram rw", 32'(1'b0), 32'(last_rw));
        check_value("wram be", 32'(2'b01), 32'(last_be));
        check_value("wram data", 32'(16'hbeef), 32'(last_data));
        check_value("wram toggles", 32'(toggles + 1), 32'(toggle_count));
        pattern = fill_word(expect_addr[8:1]);
        bus_read(24'h100456, FC_DATA, data);
        check_value("wram readback", 32'({pattern[15:8], 8'hef}), 32'(data));
    endtask

    task automatic save_sequence();
        f2_pkg::cpu_word_t data;
        int                i;
        int                settle;
        int                writes_before;
        writes_before = write_count;
        @(posedge clk);
        ss_do_save <= 1'b1;
        @(posedge clk);
        @(negedge clk);
        check_value("save irq", 32'(expected_ipl(3'd7)), 32'(ipl_n));
        wait_state(f2_pkg::START_SAVE, 10);

        bus_read(f2_pkg::AUTOVEC7_ADDR, FC_DATA, data);
        check_value("autovector high", 32'(16'h00ff), 32'(data));
        bus_read(f2_pkg::AUTOVEC7_ADDR + 24'd2, FC_DATA, data);
        check_value("autovector low", 32'(16'h0000), 32'(data));
        acknowledge(3'd7);
        check_value("save irq ack", 32'(3'b111), 32'(ipl_n));

        for (i = 0; i < 13; i++) begin
            bus_read(f2_pkg::SS_HANDLER_BASE + 24'(2 * i), FC_PROG, data);
            check_value($sformatf("handler word %0d", i),
                        32'(f2_pkg::SAVE_HANDLER[i]), 32'(data));
        end

        bus_write(f2_pkg::SS_HANDLER_BASE, 2'b00, 16'h0010);
        bus_write(f2_pkg::SS_HANDLER_BASE + 24'd2, 2'b00, 16'hff80);
        wait_state(f2_pkg::SAVE_SETTLE, 5);
        check_value("save pause", 32'(1'b1), 32'(cpu_pause));
        settle = 0;
        while (!ss_write) begin
            settle++;
            check_true(settle <= 100, "ss_write never rose after the settle time");
            @(negedge clk);
        end
        check_value("save settle cycles", 32'(SETTLE_CYCLES + 1), 32'(settle));

        wait_state(f2_pkg::IDLE, 50);
        check_value("saved ssp", 32'h0010_ff80, saved_ssp);
        check_value("save writes", 32'(writes_before + 1), 32'(write_count));
        check_value("save pause released", 32'(1'b0), 32'(cpu_pause));
        @(posedge clk);
        ss_do_save <= 1'b0;
    endtask

    task automatic restore_sequence();
        f2_pkg::cpu_word_t data;
        int                hold;
        int                reads_before;
        int                toggles;
        reads_before = read_count;
        @(posedge clk);
        ss_do_restore <= 1'b1;
        wait_state(f2_pkg::RESTORE_SETTLE, 10);
        check_value("restore reset", 32'(1'b1), 32'(cpu_reset));
        wait_state(f2_pkg::HOLD_RESET, 100);
        check_value("restore reads", 32'(reads_before + 1), 32'(read_count));
        check_value("hold reset", 32'(1'b1), 32'(cpu_reset));
        hold = 0;
        while (ss_state == f2_pkg::HOLD_RESET) begin
            hold++;
            check_true(hold <= 1000, "CPU reset was never released after restore");
            @(negedge clk);
        end
        check_value("hold cycles", 32'(HOLD_CYCLES + 1), 32'(hold));
        check_value("restart state", 32'(f2_pkg::WAIT_RESTART), 32'(ss_state));
        check_value("reset released", 32'(1'b0), 32'(cpu_reset));

        // Synthetic reset vector
        toggles = toggle_count;
        bus_read(24'h000000, FC_PROG, data);
        check_value("vector ssp high", 32'(RESTORE_SP[31:16]), 32'(data));
        bus_read(24'h000002, FC_PROG, data);
        check_value("vector ssp low", 32'(RESTORE_SP[15:0]), 32'(data));
        bus_read(24'h000004, FC_PROG, data);
        check_value("vector pc high", 32'(16'h00ff), 32'(data));
        bus_read(24'h000006, FC_PROG, data);
        check_value("vector pc low", 32'(16'h0008), 32'(data));
        check_value("vector toggles", 32'(toggles), 32'(toggle_count));

        bus_write(f2_pkg::SS_HANDLER_BASE + 24'd2, 2'b00, 16'hfff0);
        wait_state(f2_pkg::IDLE, 10);
        bus_read(24'h000000, FC_PROG, data);
        check_value("rom after restart", 32'(fill_word(8'h00)), 32'(data));
        check_value("rom after restart toggles", 32'(toggles + 1), 32'(toggle_count));
        @(posedge clk);
        ss_do_restore <= 1'b0;
    endtask

    initial begin
        reset         = 1'b1;
        cpu           = '{word_addr: '0, ds_n: 2'b11, rw: 1'b1, fc: FC_DATA, dout: '0};
        vblank_n      = 1'b1;
        dma_n         = 1'b0;
        ss_do_save    = 1'b0;
        ss_do_restore = 1'b0;
        repeat (10) @(posedge clk);
        reset <= 1'b0;
        repeat (2) @(posedge clk);

        interrupt_priority();
        rom_read();
        work_ram_byte_write();
        save_sequence();
        restore_sequence();

        $display("TEST OK");
        $finish;
    end

endmodule

`default_nettype wire

/* flist.f */
verilog/f2_pkg.sv
verilog/irq_controller.sv
verilog/ss_sequencer.sv
verilog/cpu_bus_decode.sv
verilog/sdr_cpu_bridge.sv
verilog/f2_cpu_support.sv
tb/tb_f2_cpu_support.sv

/* Makefile */
VERILATOR  ?= verilator
FLIST      ?= flist.f
TB_TOP     ?= tb_f2_cpu_support
RTL_TOP    ?= f2_cpu_support
BUILD_DIR  ?= obj_dir
VFLAGS     ?= --binary --timing -j 0
LINT_FLAGS ?= --lint-only

SOURCES     := $(shell cat $(FLIST))
RTL_SOURCES := $(filter verilog/%,$(SOURCES))
SIM_BIN     := $(BUILD_DIR)/V$(TB_TOP)

.PHONY: all build run lint clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(FLIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TB_TOP) --Mdir $(BUILD_DIR) -f $(FLIST)

run: $(SIM_BIN)
	$(SIM_BIN)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) $(RTL_SOURCES)

clean:
	rm -rf $(BUILD_DIR)
